// ==== rtl/line_cache_pkg.sv ====
`default_nettype none

package line_cache_pkg;

    // word geometry
    localparam int BYTES_PER_WORD = 4;
    localparam int BITS_PER_WORD  = 32;

    // line geometry
    localparam int LINE_WORDS  = 16;
    localparam int OFFSET_BITS = 4;
    localparam int ALIGN_BITS  = 2;
    localparam int TAG_BITS    = 26;

    // burst length as log2 of beats
    localparam int LINE_ORDER = 4;

    typedef logic [7:0]                  byte_t;
    typedef logic [BITS_PER_WORD-1:0]    word_t;
    typedef logic [BYTES_PER_WORD-1:0]   strobe_t;

    // whole word or its byte lanes
    typedef union packed {
        word_t                         word;
        byte_t [BYTES_PER_WORD-1:0]    bytes;
    } view_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [OFFSET_BITS-1:0] offset;
        logic [ALIGN_BITS-1:0]  align;
    } line_addr_t;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } access_size_t;

    // client side, sram-like
    typedef struct packed {
        logic         req;
        logic         wr;
        access_size_t size;
        line_addr_t   addr;
        view_t        wdata;
    } client_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        view_t rdata;
    } client_resp_t;

    // cache bus, one okay per beat
    typedef logic [3:0] cbus_order_t;

    typedef struct packed {
        logic        valid;
        logic        is_write;
        cbus_order_t order;
        line_addr_t  addr;
        view_t       wdata;
    } cbus_req_t;

    typedef struct packed {
        logic  okay;
        logic  last;
        view_t rdata;
    } cbus_resp_t;

endpackage

`default_nettype wire

// ==== rtl/line_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_buffer
    import line_cache_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  client_req_t  client_req,
    output client_resp_t client_resp,
    output cbus_req_t    cbus_req,
    input  cbus_resp_t   cbus_resp
);

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL
    } state_t;

    // byte lanes touched by an access
    function automatic strobe_t decode_strobe(
        access_size_t          size,
        logic [ALIGN_BITS-1:0] align
    );
        strobe_t strb;
        case (size)
            SIZE_BYTE: strb = strobe_t'(1) << align;
            SIZE_HALF: strb = align[1] ? 4'b1100 : 4'b0011;
            default:   strb = '1;
        endcase
        return strb;
    endfunction

    function automatic view_t merge_bytes(view_t base, view_t patch, strobe_t strb);
        view_t result;
        result = base;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (strb[i]) begin
                result.bytes[i] = patch.bytes[i];
            end
        end
        return result;
    endfunction

    state_t                 state;
    logic                   line_valid;
    logic                   dirty;
    logic [TAG_BITS-1:0]    tag;
    view_t                  mem [LINE_WORDS];
    logic [OFFSET_BITS-1:0] offset;

    // request captured on a miss
    line_addr_t             saved_addr;
    logic                   saved_wr;
    strobe_t                saved_strb;
    view_t                  saved_wdata;

    line_addr_t             req_addr;
    strobe_t                req_strb;
    logic                   tag_hit;
    logic                   beat_hit;
    logic                   beat_last;
    view_t                  refill_word;

    assign req_addr  = client_req.addr;
    assign req_strb  = decode_strobe(client_req.size, req_addr.align);
    assign tag_hit   = line_valid && (tag == req_addr.tag);
    assign beat_hit  = offset == saved_addr.offset;
    assign beat_last = cbus_resp.okay && cbus_resp.last;

    // write miss lands its bytes on the matching beat
    assign refill_word = (saved_wr && beat_hit) ?
        merge_bytes(cbus_resp.rdata, saved_wdata, saved_strb) : cbus_resp.rdata;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state      <= IDLE;
            line_valid <= 1'b0;
            dirty      <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (client_req.req) begin
                        if (tag_hit) begin
                            if (client_req.wr) begin
                                dirty <= 1'b1;
                            end
                        end else begin
                            state <= dirty ? WRITEBACK : REFILL;
                        end
                    end
                end
                WRITEBACK: begin
                    if (beat_last) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (beat_last) begin
                        state      <= IDLE;
                        line_valid <= 1'b1;
                        dirty      <= saved_wr;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (client_req.req) begin
                    if (tag_hit) begin
                        if (client_req.wr) begin
                            mem[req_addr.offset] <= merge_bytes(mem[req_addr.offset],
                                client_req.wdata, req_strb);
                        end
                    end else begin
                        saved_addr  <= req_addr;
                        saved_wr    <= client_req.wr;
                        saved_strb  <= req_strb;
                        saved_wdata <= client_req.wdata;
                        // write-back always starts at word 0
                        offset      <= dirty ? '0 : req_addr.offset;
                    end
                end
            end
            WRITEBACK: begin
                if (beat_last) begin
                    offset <= saved_addr.offset;
                end else if (cbus_resp.okay) begin
                    offset <= offset + 1'b1;
                end
            end
            REFILL: begin
                if (cbus_resp.okay) begin
                    mem[offset] <= refill_word;
                    // wraps inside the line
                    offset      <= offset + 1'b1;
                end
                if (beat_last) begin
                    tag <= saved_addr.tag;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        client_resp.addr_ok = state == IDLE;
        client_resp.data_ok = (state == IDLE && client_req.req && tag_hit) ||
                              (state == REFILL && cbus_resp.okay && beat_hit);
        // hit reads the array and a miss forwards the beat
        client_resp.rdata   = (state == IDLE) ? mem[req_addr.offset] : cbus_resp.rdata;
    end

    always_comb begin
        cbus_req.valid       = state != IDLE;
        cbus_req.is_write    = state == WRITEBACK;
        cbus_req.order       = cbus_order_t'(LINE_ORDER);
        cbus_req.wdata       = mem[offset];
        cbus_req.addr.tag    = (state == WRITEBACK) ? tag : saved_addr.tag;
        cbus_req.addr.offset = (state == WRITEBACK) ? '0 : saved_addr.offset;
        cbus_req.addr.align  = '0;
    end

    // no beat is routed to an idle buffer
    assert property (@(posedge clk) disable iff (resetn)
        state == IDLE |-> !cbus_resp.okay);

    // a burst keeps valid up until its final beat
    assert property (@(posedge clk) disable iff (resetn)
        cbus_req.valid && !beat_last |=> cbus_req.valid);

endmodule

`default_nettype wire

// ==== rtl/burst_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module burst_arbiter
    import line_cache_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  cbus_req_t  a_req,
    input  cbus_req_t  b_req,
    output cbus_resp_t a_resp,
    output cbus_resp_t b_resp,
    output cbus_req_t  bus_req,
    input  cbus_resp_t bus_resp
);

    // owner 0 is port a, 1 is port b
    logic      owner;
    logic      busy;
    logic      burst_done;
    logic      last_served;
    logic      pick_b;
    cbus_req_t owner_req;

    assign owner_req = owner ? b_req : a_req;

    // alternate when both ask
    assign pick_b = b_req.valid && (!a_req.valid || last_served == 1'b0);

    always_ff @(posedge clk) begin
        if (resetn) begin
            owner       <= 1'b0;
            busy        <= 1'b0;
            burst_done  <= 1'b0;
            last_served <= 1'b1;
        end else if (!busy) begin
            if (a_req.valid || b_req.valid) begin
                busy        <= 1'b1;
                burst_done  <= 1'b0;
                owner       <= pick_b;
                last_served <= pick_b;
            end
        end else begin
            if (bus_resp.okay && bus_resp.last) begin
                burst_done <= 1'b1;
            end else if (burst_done) begin
                burst_done <= 1'b0;
                // still valid means a refill follows the write-back
                if (!owner_req.valid) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        bus_req = busy ? owner_req : '0;

        a_resp       = bus_resp;
        b_resp       = bus_resp;
        a_resp.okay  = busy && !owner && bus_resp.okay;
        a_resp.last  = busy && !owner && bus_resp.last;
        b_resp.okay  = busy && owner && bus_resp.okay;
        b_resp.last  = busy && owner && bus_resp.last;
    end

    assert property (@(posedge clk) disable iff (resetn)
        busy |=> $stable(owner));

endmodule

`default_nettype wire

// ==== rtl/dual_port_line_cache.sv ====
`timescale 1ns/100ps
`default_nettype none

module dual_port_line_cache
    import line_cache_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  client_req_t  a_req,
    output client_resp_t a_resp,
    input  client_req_t  b_req,
    output client_resp_t b_resp,
    output cbus_req_t    bus_req,
    input  cbus_resp_t   bus_resp
);

    cbus_req_t  a_cbus_req;
    cbus_resp_t a_cbus_resp;
    cbus_req_t  b_cbus_req;
    cbus_resp_t b_cbus_resp;

    // instruction side
    line_buffer u_buffer_a (
        .clk         (clk),
        .resetn      (resetn),
        .client_req  (a_req),
        .client_resp (a_resp),
        .cbus_req    (a_cbus_req),
        .cbus_resp   (a_cbus_resp)
    );

    // data side
    line_buffer u_buffer_b (
        .clk         (clk),
        .resetn      (resetn),
        .client_req  (b_req),
        .client_resp (b_resp),
        .cbus_req    (b_cbus_req),
        .cbus_resp   (b_cbus_resp)
    );

    burst_arbiter u_arbiter (
        .clk      (clk),
        .resetn   (resetn),
        .a_req    (a_cbus_req),
        .b_req    (b_cbus_req),
        .a_resp   (a_cbus_resp),
        .b_resp   (b_cbus_resp),
        .bus_req  (bus_req),
        .bus_resp (bus_resp)
    );

endmodule

`default_nettype wire

// ==== testbench/cbus_memory_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module cbus_memory_model
    import line_cache_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  cbus_req_t  bus_req,
    output cbus_resp_t bus_resp
);

    localparam int MEM_WORDS = 1024;

    word_t                  mem [MEM_WORDS];
    logic                   active;
    logic                   is_write;
    cbus_order_t            burst_order;
    logic [5:0]             line;
    logic [OFFSET_BITS-1:0] beat_offset;
    logic [OFFSET_BITS-1:0] beats_done;
    int                     wait_left;
    integer                 seed = 55401;

    initial begin
        bus_resp = '0;
        active   = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = i * 32'h0101_0101 + 32'h1000;
        end
    end

    // answers change on the falling edge so the buffers take a beat on the rising one
    always @(negedge clk) begin
        if (resetn) begin
            active   <= 1'b0;
            bus_resp <= '0;
        end else if (bus_resp.okay) begin
            bus_resp.okay <= 1'b0;
            bus_resp.last <= 1'b0;
            active        <= !bus_resp.last;
            beat_offset   <= beat_offset + 1'b1;
            beats_done    <= beats_done + 1'b1;
            wait_left     <= {$random(seed)} % 4;
        end else if (!active) begin
            if (bus_req.valid) begin
                active      <= 1'b1;
                is_write    <= bus_req.is_write;
                burst_order <= bus_req.order;
                line        <= bus_req.addr.tag[5:0];
                beat_offset <= bus_req.addr.offset;
                beats_done  <= '0;
                wait_left   <= {$random(seed)} % 4;
            end
        end else if (wait_left != 0) begin
            wait_left <= wait_left - 1;
        end else begin
            bus_resp.okay <= 1'b1;
            bus_resp.last <= beats_done == (1 << burst_order) - 1;
            // burst wraps inside the line
            if (is_write) begin
                mem[{line, beat_offset}] <= bus_req.wdata.word;
            end else begin
                bus_resp.rdata.word <= mem[{line, beat_offset}];
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_dual_port_line_cache.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dual_port_line_cache
    import line_cache_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 5;
    localparam int MEM_WORDS      = 1024;
    localparam int PORT_WORDS     = 512;
    localparam int RANDOM_OPS     = 200;
    localparam int DIRECTED_REQS  = 80;
    localparam int TIMEOUT_CYCLES = (DIRECTED_REQS + RANDOM_OPS) * 2 * LINE_WORDS * 4 + 2000;

    logic         clk = 1'b0;
    logic         resetn;
    client_req_t  a_req;
    client_req_t  b_req;
    client_resp_t a_resp;
    client_resp_t b_resp;
    cbus_req_t    bus_req;
    cbus_resp_t   bus_resp;
    word_t        shadow [MEM_WORDS];
    // expected read data per port, set when the request is issued
    logic         pending_read [2];
    word_t        pending_exp [2];
    logic         last_hit [2];
    integer       seed;
    int           errors;
    int           checks;
    int           tests;
    int           reported_errors;
    int           cycle_count;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dual_port_line_cache u_dut (
        .clk      (clk),
        .resetn   (resetn),
        .a_req    (a_req),
        .a_resp   (a_resp),
        .b_req    (b_req),
        .b_resp   (b_resp),
        .bus_req  (bus_req),
        .bus_resp (bus_resp)
    );

    cbus_memory_model u_memory (
        .clk      (clk),
        .resetn   (resetn),
        .bus_req  (bus_req),
        .bus_resp (bus_resp)
    );

    // applies writes to the shadow copy, returns the current word
    function automatic word_t expected_word(logic wr, access_size_t size, logic [31:0] addr,
                                            word_t wdata);
        int idx;
        int lanes;
        int first;
        idx   = (addr >> 2) % MEM_WORDS;
        lanes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
        first = (addr % 4) / lanes * lanes;
        if (wr) begin
            for (int lane = first; lane < first + lanes; lane++) begin
                shadow[idx][lane*8 +: 8] = wdata[lane*8 +: 8];
            end
        end
        return shadow[idx];
    endfunction

    task automatic check_value(string signal, word_t expected, word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, signal, expected, actual);
        end
    endtask

    function automatic logic [31:0] word_addr(int port, int line, int offset);
        return (port * PORT_WORDS + line * LINE_WORDS + offset) * BYTES_PER_WORD;
    endfunction

    task automatic drive_port(int port, client_req_t value);
        if (port == 0) begin
            a_req = value;
        end else begin
            b_req = value;
        end
    endtask

    // one request, returns after its data_ok
    task automatic access(int port, logic wr, access_size_t size, logic [31:0] addr,
                          word_t wdata);
        client_req_t  request;
        client_resp_t resp;
        request.req        = 1'b1;
        request.wr         = wr;
        request.size       = size;
        request.addr       = line_addr_t'(addr);
        request.wdata.word = wdata;
        @(negedge clk);
        pending_read[port] = !wr;
        pending_exp[port]  = expected_word(wr, size, addr, wdata);
        drive_port(port, request);
        do begin
            @(posedge clk);
            resp = (port == 0) ? a_resp : b_resp;
        end while (!resp.addr_ok);
        last_hit[port] = resp.data_ok;
        while (!resp.data_ok) begin
            @(posedge clk);
            resp = (port == 0) ? a_resp : b_resp;
        end
        @(negedge clk);
        drive_port(port, '0);
    endtask

    task automatic random_traffic(int port);
        int           line;
        int           offset;
        access_size_t size;
        logic [1:0]   align;
        for (int n = 0; n < RANDOM_OPS / 2; n++) begin
            // four lines spread over the window, so hits and evictions mix
            line   = ({$random(seed)} % 4) * 8 + 1;
            offset = {$random(seed)} % LINE_WORDS;
            size   = access_size_t'({$random(seed)} % 3);
            align  = 2'($random(seed));
            align  = (size == SIZE_BYTE) ? align : (size == SIZE_HALF) ? (align & 2'b10) : 2'b00;
            access(port, 1'($random(seed)), size, word_addr(port, line, offset) + align,
                   $random(seed));
        end
    endtask

    task automatic end_test(string name);
        @(negedge clk);
        tests++;
        $display("test %0d %s done with %0d errors", tests, name, errors - reported_errors);
        reported_errors = errors;
    endtask

    always @(posedge clk) begin
        if (!resetn && a_resp.data_ok && pending_read[0]) begin
            check_value("a_resp.rdata", pending_exp[0], a_resp.rdata.word);
        end
        if (!resetn && b_resp.data_ok && pending_read[1]) begin
            check_value("b_resp.rdata", pending_exp[1], b_resp.rdata.word);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a request never saw data_ok", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        seed            = 55401;
        a_req           = '0;
        b_req           = '0;
        resetn          = 1'b1;
        errors          = 0;
        checks          = 0;
        tests           = 0;
        reported_errors = 0;
        cycle_count     = 0;
        pending_read[0] = 1'b0;
        pending_read[1] = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = i * 32'h0101_0101 + 32'h1000;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b0;

        access(0, 1'b0, SIZE_WORD, word_addr(0, 3, 5), '0);
        check_value("a_resp.data_ok on miss", 0, last_hit[0]);
        for (int i = 0; i < LINE_WORDS; i++) begin
            if (i != 5) begin
                access(0, 1'b0, SIZE_WORD, word_addr(0, 3, i), '0);
                check_value("a_resp.data_ok on hit", 1, last_hit[0]);
            end
        end
        end_test("read miss then line hits");

        access(0, 1'b1, SIZE_BYTE, word_addr(0, 3, 2) + 1, 32'hA5A5_A5A5);
        access(0, 1'b1, SIZE_BYTE, word_addr(0, 3, 4) + 3, 32'h5A5A_5A5A);
        access(0, 1'b1, SIZE_HALF, word_addr(0, 3, 7) + 2, 32'h1234_5678);
        access(0, 1'b1, SIZE_WORD, word_addr(0, 3, 9), 32'hDEAD_BEEF);
        for (int i = 1; i <= 10; i++) begin
            access(0, 1'b0, SIZE_WORD, word_addr(0, 3, i), '0);
        end
        end_test("strobed writes to a resident line");

        // line 3 is dirty, so the miss drains it first
        access(0, 1'b1, SIZE_BYTE, word_addr(0, 10, 6) + 1, 32'h0000_7700);
        check_value("a_resp.data_ok on miss", 0, last_hit[0]);
        for (int i = 5; i <= 7; i++) begin
            access(0, 1'b0, SIZE_WORD, word_addr(0, 10, i), '0);
        end
        end_test("write miss merge");

        access(0, 1'b1, SIZE_WORD, word_addr(0, 10, 0), 32'h0BAD_CAFE);
        access(0, 1'b1, SIZE_HALF, word_addr(0, 10, 15), 32'h0000_BEEF);
        access(0, 1'b0, SIZE_WORD, word_addr(0, 20, 0), '0);
        for (int i = 0; i < LINE_WORDS; i++) begin
            access(0, 1'b0, SIZE_WORD, word_addr(0, 10, i), '0);
        end
        for (int i = 1; i <= 10; i++) begin
            access(0, 1'b0, SIZE_WORD, word_addr(0, 3, i), '0);
        end
        end_test("dirty write-back and return");

        fork
            begin
                access(0, 1'b1, SIZE_WORD, word_addr(0, 30, 11), 32'h1357_9BDF);
                access(0, 1'b0, SIZE_WORD, word_addr(0, 31, 4), '0);
                access(0, 1'b0, SIZE_WORD, word_addr(0, 30, 11), '0);
            end
            begin
                access(1, 1'b0, SIZE_WORD, word_addr(1, 8, 3), '0);
                access(1, 1'b1, SIZE_HALF, word_addr(1, 9, 0), 32'h0000_4242);
                access(1, 1'b0, SIZE_WORD, word_addr(1, 8, 3), '0);
                access(1, 1'b0, SIZE_WORD, word_addr(1, 9, 0), '0);
            end
        join
        end_test("both ports miss together");

        fork
            random_traffic(0);
            random_traffic(1);
        join
        end_test("random mixed traffic");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/line_cache_pkg.sv
rtl/line_buffer.sv
rtl/burst_arbiter.sv
rtl/dual_port_line_cache.sv
testbench/cbus_memory_model.sv
testbench/tb_dual_port_line_cache.sv
